/* subsys_pkg.sv */
// Shared constants of the peripheral subsystem
// Address map, register offsets, bus widths and interrupt source ids
`default_nettype none

package subsys_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////
  localparam int addr_w   = 32;
  localparam int data_w   = 32;
  localparam int region_w = 16;
  localparam int off_w    = 16;

  // Region select, top address bits
  localparam logic [region_w-1:0] clint_base = 16'h0200;
  localparam logic [region_w-1:0] plic_base  = 16'h0C00;
  localparam logic [region_w-1:0] gpio_base  = 16'h1001;

  //////////////////////////////////////////////////////////////////////
  // Timer registers
  //////////////////////////////////////////////////////////////////////
  localparam logic [off_w-1:0] clint_msip_off    = 16'h0000;
  localparam logic [off_w-1:0] clint_cmp_lo_off  = 16'h4000;
  localparam logic [off_w-1:0] clint_cmp_hi_off  = 16'h4004;
  localparam logic [off_w-1:0] clint_time_lo_off = 16'hBFF8;
  localparam logic [off_w-1:0] clint_time_hi_off = 16'hBFFC;
  localparam int               time_w            = 64;

  //////////////////////////////////////////////////////////////////////
  // Interrupt controller
  //////////////////////////////////////////////////////////////////////
  localparam logic [off_w-1:0] plic_pend_off  = 16'h1000;
  localparam logic [off_w-1:0] plic_en_off    = 16'h2000;
  localparam logic [off_w-1:0] plic_claim_off = 16'h2004;
  localparam int               plic_src_num   = 3;
  localparam int               plic_id_w      = 2;

  // Source ids, zero means no interrupt
  localparam logic [plic_id_w-1:0] src_wdg_id  = 2'd1;
  localparam logic [plic_id_w-1:0] src_rtc_id  = 2'd2;
  localparam logic [plic_id_w-1:0] src_gpio_id = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // GPIO
  //////////////////////////////////////////////////////////////////////
  localparam int               gpio_w           = 32;
  localparam logic [off_w-1:0] gpio_in_off      = 16'h0000;
  localparam logic [off_w-1:0] gpio_oe_off      = 16'h0008;
  localparam logic [off_w-1:0] gpio_out_off     = 16'h000C;
  localparam logic [off_w-1:0] gpio_rise_ie_off = 16'h0018;
  localparam logic [off_w-1:0] gpio_rise_ip_off = 16'h001C;

endpackage

`default_nettype wire

/* subsys_fabric.sv */
// Bus fabric of the subsystem
// Takes one command at a time, decodes the region bits to the timer,
// interrupt controller or GPIO and holds the response until it is taken
`timescale 1ns/1ps
`default_nettype none

module subsys_fabric
  import subsys_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              icb_cmd_valid,
  output logic              icb_cmd_ready,
  input  logic [addr_w-1:0] icb_cmd_addr,
  input  logic              icb_cmd_read,
  input  logic [data_w-1:0] icb_cmd_wdata,
  output logic              icb_rsp_valid,
  input  logic              icb_rsp_ready,
  output logic              icb_rsp_err,
  output logic [data_w-1:0] icb_rsp_rdata,
  output logic              clint_wen,
  output logic              clint_ren,
  output logic              plic_wen,
  output logic              plic_ren,
  output logic              gpio_wen,
  output logic              gpio_ren,
  output logic [off_w-1:0]  reg_off,
  output logic [data_w-1:0] reg_wdata,
  input  logic [data_w-1:0] clint_rdata,
  input  logic [data_w-1:0] plic_rdata,
  input  logic [data_w-1:0] gpio_rdata,
  output logic [21:0]       last_addr
);

  typedef enum logic {st_idle, st_resp} state_t;

  state_t              state;
  logic [region_w-1:0] region;
  logic                hit_clint;
  logic                hit_plic;
  logic                hit_gpio;
  logic                accept;
  logic [data_w-1:0]   sel_rdata;

  // One command outstanding, ready only while idle
  assign icb_cmd_ready = (state == st_idle);
  assign icb_rsp_valid = (state == st_resp);
  assign accept        = icb_cmd_valid & icb_cmd_ready;

  assign region    = icb_cmd_addr[addr_w-1 -: region_w];
  assign hit_clint = (region == clint_base);
  assign hit_plic  = (region == plic_base);
  assign hit_gpio  = (region == gpio_base);

  assign reg_off   = icb_cmd_addr[off_w-1:0];
  assign reg_wdata = icb_cmd_wdata;

  // Strobes live only in the acceptance cycle
  assign clint_wen = accept & hit_clint & ~icb_cmd_read;
  assign clint_ren = accept & hit_clint & icb_cmd_read;
  assign plic_wen  = accept & hit_plic & ~icb_cmd_read;
  assign plic_ren  = accept & hit_plic & icb_cmd_read;
  assign gpio_wen  = accept & hit_gpio & ~icb_cmd_read;
  assign gpio_ren  = accept & hit_gpio & icb_cmd_read;

  always_comb begin
    sel_rdata = '0;
    if (hit_clint) begin
      sel_rdata = clint_rdata;
    end else if (hit_plic) begin
      sel_rdata = plic_rdata;
    end else if (hit_gpio) begin
      sel_rdata = gpio_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      last_addr <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (icb_rsp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      if (accept) begin
        last_addr <= icb_cmd_addr[21:0];
      end
    end
  end

  // Response payload, loaded once per command
  always_ff @(posedge clk) begin
    if (accept) begin
      icb_rsp_err   <= ~(hit_clint | hit_plic | hit_gpio);
      icb_rsp_rdata <= icb_cmd_read ? sel_rdata : '0;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({clint_wen, clint_ren, plic_wen, plic_ren, gpio_wen, gpio_ren}));

  a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
    icb_rsp_valid && !icb_rsp_ready |=>
      icb_rsp_valid && $stable(icb_rsp_rdata) && $stable(icb_rsp_err));

endmodule

`default_nettype wire

/* subsys_clint.sv */
// Core-local timer
// 64-bit time counter stepped by a slow toggle input, a compare register
// for the timer interrupt and a software interrupt bit
`timescale 1ns/1ps
`default_nettype none

module subsys_clint
  import subsys_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wen,
  input  logic              ren,
  input  logic [off_w-1:0]  reg_off,
  input  logic [data_w-1:0] reg_wdata,
  output logic [data_w-1:0] rdata,
  input  logic              rtc_toggle_a,
  output logic              tmr_irq,
  output logic              sft_irq
);

  logic [1:0]        rtc_sync;
  logic              rtc_prev;
  logic              tick;
  logic              time_wr;
  logic [time_w-1:0] mtime;
  logic [time_w-1:0] mtimecmp;
  logic              msip;

  // Rising edge of the synchronized toggle
  assign tick    = rtc_sync[1] & ~rtc_prev;
  assign time_wr = wen & ((reg_off == clint_time_lo_off) || (reg_off == clint_time_hi_off));

  always_ff @(posedge clk) begin
    if (reset) begin
      rtc_sync <= '0;
      rtc_prev <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc_toggle_a};
      rtc_prev <= rtc_sync[1];
      if (tick) begin
        mtime <= mtime + 1'b1;
      end
      // Register writes come last so a time write beats the tick
      if (wen) begin
        case (reg_off)
          clint_msip_off:    msip <= reg_wdata[0];
          clint_cmp_lo_off:  mtimecmp[data_w-1:0] <= reg_wdata;
          clint_cmp_hi_off:  mtimecmp[time_w-1:data_w] <= reg_wdata;
          clint_time_lo_off: mtime <= {mtime[time_w-1:data_w], reg_wdata};
          clint_time_hi_off: mtime <= {reg_wdata, mtime[data_w-1:0]};
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (ren) begin
      case (reg_off)
        clint_msip_off:    rdata = {{(data_w-1){1'b0}}, msip};
        clint_cmp_lo_off:  rdata = mtimecmp[data_w-1:0];
        clint_cmp_hi_off:  rdata = mtimecmp[time_w-1:data_w];
        clint_time_lo_off: rdata = mtime[data_w-1:0];
        clint_time_hi_off: rdata = mtime[time_w-1:data_w];
        default:           rdata = '0;
      endcase
    end
  end

  assign tmr_irq = (mtime >= mtimecmp);
  assign sft_irq = msip;

  a_time_step: assert property (@(posedge clk) disable iff (reset)
    !time_wr |=> (mtime - $past(mtime)) <= time_w'(1));

endmodule

`default_nettype wire

/* subsys_plic.sv */
// Platform interrupt controller
// Three level sources with gateways, an enable register and claim/complete
`timescale 1ns/1ps
`default_nettype none

module subsys_plic
  import subsys_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wen,
  input  logic              ren,
  input  logic [off_w-1:0]  reg_off,
  input  logic [data_w-1:0] reg_wdata,
  output logic [data_w-1:0] rdata,
  input  logic              wdg_irq_a,
  input  logic              rtc_irq_a,
  input  logic              gpio_irq,
  output logic              ext_irq
);

  logic [1:0]              wdg_sync;
  logic [1:0]              rtc_sync;
  logic [plic_src_num:1]   src_level;
  logic [plic_src_num:1]   pending;
  logic [plic_src_num:1]   in_service;
  logic [plic_src_num:1]   enable;
  logic [plic_id_w-1:0]    claim_id;
  logic                    claim_rd;
  logic                    complete_wr;

  // GPIO interrupt is already in this clock domain
  assign src_level[src_wdg_id]  = wdg_sync[1];
  assign src_level[src_rtc_id]  = rtc_sync[1];
  assign src_level[src_gpio_id] = gpio_irq;

  assign claim_rd    = ren & (reg_off == plic_claim_off);
  assign complete_wr = wen & (reg_off == plic_claim_off);

  // Lowest id wins
  always_comb begin
    claim_id = '0;
    for (int i = plic_src_num; i >= 1; i--) begin
      if (pending[i] && enable[i]) begin
        claim_id = plic_id_w'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Gateways
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wdg_sync   <= '0;
      rtc_sync   <= '0;
      pending    <= '0;
      in_service <= '0;
      enable     <= '0;
      ext_irq    <= 1'b0;
    end else begin
      wdg_sync <= {wdg_sync[0], wdg_irq_a};
      rtc_sync <= {rtc_sync[0], rtc_irq_a};
      ext_irq  <= |(pending & enable);
      if (wen && (reg_off == plic_en_off)) begin
        enable <= reg_wdata[plic_src_num:1];
      end
      for (int i = 1; i <= plic_src_num; i++) begin
        if (claim_rd && (claim_id == plic_id_w'(i))) begin
          pending[i]    <= 1'b0;
          in_service[i] <= 1'b1;
        end else if (src_level[i] && !in_service[i]) begin
          pending[i] <= 1'b1;
        end
        if (complete_wr && (reg_wdata[plic_id_w-1:0] == plic_id_w'(i))) begin
          in_service[i] <= 1'b0;
        end
      end
    end
  end

  // Bit n of pending and enable belongs to source id n
  always_comb begin
    rdata = '0;
    if (ren) begin
      case (reg_off)
        plic_pend_off:  rdata[plic_src_num:0] = {pending, 1'b0};
        plic_en_off:    rdata[plic_src_num:0] = {enable, 1'b0};
        plic_claim_off: rdata[plic_id_w-1:0] = claim_id;
        default:        rdata = '0;
      endcase
    end
  end

  a_pend_serv: assert property (@(posedge clk) disable iff (reset)
    (pending & in_service) == '0);

endmodule

`default_nettype wire

/* subsys_gpio.sv */
// 32-pad GPIO block
// Output, enable and rise-interrupt registers, plus an inspect mode that
// turns every pad into an output showing bus and interrupt activity
`timescale 1ns/1ps
`default_nettype none

module subsys_gpio
  import subsys_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wen,
  input  logic              ren,
  input  logic [off_w-1:0]  reg_off,
  input  logic [data_w-1:0] reg_wdata,
  output logic [data_w-1:0] rdata,
  input  logic [gpio_w-1:0] gpio_in,
  output logic [gpio_w-1:0] gpio_out,
  output logic [gpio_w-1:0] gpio_oe,
  output logic              gpio_irq,
  input  logic              inspect_mode,
  input  logic [21:0]       last_addr,
  input  logic              icb_cmd_valid,
  input  logic              icb_cmd_ready,
  input  logic              icb_rsp_valid,
  input  logic              icb_rsp_ready,
  input  logic              ext_irq,
  input  logic              tmr_irq,
  input  logic              sft_irq
);

  logic [gpio_w-1:0] in_sync0;
  logic [gpio_w-1:0] in_sync1;
  logic [gpio_w-1:0] in_prev;
  logic [gpio_w-1:0] out_val;
  logic [gpio_w-1:0] out_en;
  logic [gpio_w-1:0] rise_ie;
  logic [gpio_w-1:0] rise_ip;
  logic [gpio_w-1:0] rise_clr;
  logic [gpio_w-1:0] inspect_word;

  // Write one to clear, a new edge in the same cycle still sets
  assign rise_clr = (wen && (reg_off == gpio_rise_ip_off)) ? reg_wdata : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_sync0 <= '0;
      in_sync1 <= '0;
      in_prev  <= '0;
      out_val  <= '0;
      out_en   <= '0;
      rise_ie  <= '0;
      rise_ip  <= '0;
    end else begin
      in_sync0 <= gpio_in;
      in_sync1 <= in_sync0;
      in_prev  <= in_sync1;
      rise_ip  <= (rise_ip & ~rise_clr) | (in_sync1 & ~in_prev);
      if (wen) begin
        case (reg_off)
          gpio_oe_off:      out_en  <= reg_wdata;
          gpio_out_off:     out_val <= reg_wdata;
          gpio_rise_ie_off: rise_ie <= reg_wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (ren) begin
      case (reg_off)
        gpio_in_off:      rdata = in_sync1;
        gpio_oe_off:      rdata = out_en;
        gpio_out_off:     rdata = out_val;
        gpio_rise_ie_off: rdata = rise_ie;
        gpio_rise_ip_off: rdata = rise_ip;
        default:          rdata = '0;
      endcase
    end
  end

  assign gpio_irq = |(rise_ip & rise_ie);

  //////////////////////////////////////////////////////////////////////
  // Pad mux
  //////////////////////////////////////////////////////////////////////
  assign inspect_word = {3'b000, sft_irq, tmr_irq, ext_irq,
                         icb_rsp_ready, icb_rsp_valid, icb_cmd_ready, icb_cmd_valid,
                         last_addr};

  assign gpio_oe  = inspect_mode ? '1 : out_en;
  assign gpio_out = inspect_mode ? inspect_word : out_val;

endmodule

`default_nettype wire

/* subsys_main.sv */
// Top of the peripheral subsystem
// Bus fabric in front of the core-local timer, the interrupt controller
// and the GPIO block
`timescale 1ns/1ps
`default_nettype none

module subsys_main
  import subsys_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              icb_cmd_valid,
  output logic              icb_cmd_ready,
  input  logic [addr_w-1:0] icb_cmd_addr,
  input  logic              icb_cmd_read,
  input  logic [data_w-1:0] icb_cmd_wdata,
  output logic              icb_rsp_valid,
  input  logic              icb_rsp_ready,
  output logic              icb_rsp_err,
  output logic [data_w-1:0] icb_rsp_rdata,
  input  logic              rtc_toggle_a,
  input  logic              wdg_irq_a,
  input  logic              rtc_irq_a,
  input  logic [gpio_w-1:0] gpio_in,
  output logic [gpio_w-1:0] gpio_out,
  output logic [gpio_w-1:0] gpio_oe,
  input  logic              inspect_mode,
  output logic              ext_irq,
  output logic              tmr_irq,
  output logic              sft_irq
);

  logic              clint_wen;
  logic              clint_ren;
  logic              plic_wen;
  logic              plic_ren;
  logic              gpio_wen;
  logic              gpio_ren;
  logic [off_w-1:0]  reg_off;
  logic [data_w-1:0] reg_wdata;
  logic [data_w-1:0] clint_rdata;
  logic [data_w-1:0] plic_rdata;
  logic [data_w-1:0] gpio_rdata;
  logic [21:0]       last_addr;
  logic              gpio_irq;

  subsys_fabric u_fabric (
    .clk           (clk),
    .reset         (reset),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd_addr  (icb_cmd_addr),
    .icb_cmd_read  (icb_cmd_read),
    .icb_cmd_wdata (icb_cmd_wdata),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp_err   (icb_rsp_err),
    .icb_rsp_rdata (icb_rsp_rdata),
    .clint_wen     (clint_wen),
    .clint_ren     (clint_ren),
    .plic_wen      (plic_wen),
    .plic_ren      (plic_ren),
    .gpio_wen      (gpio_wen),
    .gpio_ren      (gpio_ren),
    .reg_off       (reg_off),
    .reg_wdata     (reg_wdata),
    .clint_rdata   (clint_rdata),
    .plic_rdata    (plic_rdata),
    .gpio_rdata    (gpio_rdata),
    .last_addr     (last_addr)
  );

  subsys_clint u_clint (
    .clk          (clk),
    .reset        (reset),
    .wen          (clint_wen),
    .ren          (clint_ren),
    .reg_off      (reg_off),
    .reg_wdata    (reg_wdata),
    .rdata        (clint_rdata),
    .rtc_toggle_a (rtc_toggle_a),
    .tmr_irq      (tmr_irq),
    .sft_irq      (sft_irq)
  );

  subsys_plic u_plic (
    .clk       (clk),
    .reset     (reset),
    .wen       (plic_wen),
    .ren       (plic_ren),
    .reg_off   (reg_off),
    .reg_wdata (reg_wdata),
    .rdata     (plic_rdata),
    .wdg_irq_a (wdg_irq_a),
    .rtc_irq_a (rtc_irq_a),
    .gpio_irq  (gpio_irq),
    .ext_irq   (ext_irq)
  );

  // Bus handshake and irq levels feed the inspect word
  subsys_gpio u_gpio (
    .clk           (clk),
    .reset         (reset),
    .wen           (gpio_wen),
    .ren           (gpio_ren),
    .reg_off       (reg_off),
    .reg_wdata     (reg_wdata),
    .rdata         (gpio_rdata),
    .gpio_in       (gpio_in),
    .gpio_out      (gpio_out),
    .gpio_oe       (gpio_oe),
    .gpio_irq      (gpio_irq),
    .inspect_mode  (inspect_mode),
    .last_addr     (last_addr),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .ext_irq       (ext_irq),
    .tmr_irq       (tmr_irq),
    .sft_irq       (sft_irq)
  );

endmodule

`default_nettype wire

/* tb_subsys_main.sv */
// Testbench for the peripheral subsystem
// Replays the stimulus table against the bus, the pins and the irq outputs
`timescale 1ns/1ps
`default_nettype none

module tb_subsys_main;

  localparam int clk_half    = 20;
  localparam int ack_limit   = 16;
  localparam int poll_limit  = 24;
  localparam int wd_per_line = 40;

  logic        clk = 1'b0;
  logic        reset;
  logic        icb_cmd_valid;
  logic        icb_cmd_ready;
  logic [31:0] icb_cmd_addr;
  logic        icb_cmd_read;
  logic [31:0] icb_cmd_wdata;
  logic        icb_rsp_valid;
  logic        icb_rsp_ready;
  logic        icb_rsp_err;
  logic [31:0] icb_rsp_rdata;
  logic        rtc_toggle_a;
  logic        wdg_irq_a;
  logic        rtc_irq_a;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_oe;
  logic        inspect_mode;
  logic        ext_irq;
  logic        tmr_irq;
  logic        sft_irq;

  // Stimulus table, one entry per line of the file
  int          test_q[$];
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];
  logic        err_q[$];

  logic        loaded = 1'b0;
  int          stall_next;
  logic [21:0] seen_addr;
  int          check_cnt;
  int          fail_cnt;
  int          test_pass;
  int          test_fail;

  subsys_main subsys_main_i (.*);

  always #clk_half clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    check_cnt++;
    assert (got === want) else begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
      fail_cnt++;
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    int          tid;
    int          f;
    string       line;
    string       op_s;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("subsys_stim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the stimulus file subsys_stim.txt could not be opened");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%d %s %h %h %h %d", tid, op_s, a, d, e, f);
          if (n == 6) begin
            test_q.push_back(tid);
            op_q.push_back(op_s[0]);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
            err_q.push_back(f != 0);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One command and its response, starting and ending on a falling edge
  task automatic bus_xfer(input logic rd, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    icb_cmd_valid = 1'b1;
    icb_cmd_addr  = addr;
    icb_cmd_read  = rd;
    icb_cmd_wdata = wdata;
    icb_rsp_ready = (stall_next == 0);
    while (!icb_cmd_ready && waited < ack_limit) begin
      @(negedge clk);
      waited++;
    end
    assert (icb_cmd_ready) else begin
      $display("ERROR at %0t ns: command to %h was never accepted", $time, addr);
      fail_cnt++;
    end
    seen_addr = addr[21:0];
    @(negedge clk);
    icb_cmd_valid = 1'b0;
    check_value("rsp_valid one cycle after accept", 32'(icb_rsp_valid), 32'd1);
    rdata = icb_rsp_rdata;
    err   = icb_rsp_err;
    for (int i = 0; i < stall_next; i++) begin
      @(negedge clk);
      check_value("rsp_valid under stall", 32'(icb_rsp_valid), 32'd1);
      check_value("cmd_ready under stall", 32'(icb_cmd_ready), 32'd0);
      check_value("rdata under stall", icb_rsp_rdata, rdata);
      check_value("err under stall", 32'(icb_rsp_err), 32'(err));
    end
    icb_rsp_ready = 1'b1;
    stall_next    = 0;
    @(negedge clk);
    check_value("cmd_ready after response", 32'(icb_cmd_ready), 32'd1);
    check_value("rsp_valid after response", 32'(icb_rsp_valid), 32'd0);
  endtask

  // 8 cycles per pulse, half high and half low
  task automatic pulse_toggle(input int count);
    repeat (count) begin
      rtc_toggle_a = 1'b1;
      repeat (4) @(negedge clk);
      rtc_toggle_a = 1'b0;
      repeat (4) @(negedge clk);
    end
  endtask

  // Pad word in inspect mode: address, handshake, then irq levels
  function automatic logic [31:0] inspect_expect();
    return {3'b000, sft_irq, tmr_irq, ext_irq, icb_rsp_ready, icb_rsp_valid,
            icb_cmd_ready, icb_cmd_valid, seen_addr};
  endfunction

  function automatic logic [31:0] observe(input logic [31:0] sel);
    case (sel)
      32'd0:   return {29'd0, ext_irq, tmr_irq, sft_irq};
      32'd2:   return gpio_oe;
      default: return gpio_out;
    endcase
  endfunction

  // Polls until the outputs match, synchronizers add a few cycles
  task automatic check_outputs(input logic [31:0] sel, input logic [31:0] want_in);
    int          waited;
    logic [31:0] want;
    string       label;
    waited = 0;
    case (sel)
      32'd0:   label = "irq {ext,tmr,sft}";
      32'd1:   label = "gpio_out";
      32'd2:   label = "gpio_oe";
      default: label = "inspect word";
    endcase
    want = (sel == 32'd3) ? inspect_expect() : want_in;
    while (observe(sel) !== want && waited < poll_limit) begin
      @(negedge clk);
      waited++;
      if (sel == 32'd3) begin
        want = inspect_expect();
      end
    end
    check_value(label, observe(sel), want);
  endtask

  task automatic report_test(input int id, input int errs);
    if (errs == 0) begin
      test_pass++;
      $display("test %0d passed", id);
    end else begin
      test_fail++;
      $display("test %0d failed with %0d errors", id, errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    logic        err;
    int          cur_test;
    int          test_start;
    reset         = 1'b1;
    icb_cmd_valid = 1'b0;
    icb_cmd_addr  = '0;
    icb_cmd_read  = 1'b0;
    icb_cmd_wdata = '0;
    icb_rsp_ready = 1'b1;
    rtc_toggle_a  = 1'b0;
    wdg_irq_a     = 1'b0;
    rtc_irq_a     = 1'b0;
    gpio_in       = '0;
    inspect_mode  = 1'b0;
    stall_next    = 0;
    seen_addr     = '0;
    check_cnt     = 0;
    fail_cnt      = 0;
    test_pass     = 0;
    test_fail     = 0;
    load_stim();
    loaded = 1'b1;
    cur_test   = (test_q.size() > 0) ? test_q[0] : 0;
    test_start = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("cmd_ready after reset", 32'(icb_cmd_ready), 32'd1);
    check_value("rsp_valid after reset", 32'(icb_rsp_valid), 32'd0);
    check_value("irqs after reset", {29'd0, ext_irq, tmr_irq, sft_irq}, 32'd0);
    foreach (op_q[i]) begin
      if (test_q[i] != cur_test) begin
        report_test(cur_test, fail_cnt - test_start);
        cur_test   = test_q[i];
        test_start = fail_cnt;
      end
      case (op_q[i])
        "W": begin
          bus_xfer(1'b0, addr_q[i], data_q[i], rdata, err);
          check_value("write err flag", 32'(err), 32'(err_q[i]));
        end
        "R": begin
          bus_xfer(1'b1, addr_q[i], data_q[i], rdata, err);
          check_value("read data", rdata, exp_q[i]);
          check_value("read err flag", 32'(err), 32'(err_q[i]));
        end
        "P": begin
          if (addr_q[i] == 32'd0) begin
            gpio_in = data_q[i];
          end else begin
            {inspect_mode, rtc_irq_a, wdg_irq_a} = data_q[i][2:0];
          end
        end
        "K": pulse_toggle(int'(data_q[i]));
        "I": check_outputs(addr_q[i], exp_q[i]);
        "S": stall_next = int'(data_q[i]);
        default: begin
          $display("ERROR: unknown operation code %c in the stimulus file", op_q[i]);
          fail_cnt++;
        end
      endcase
    end
    report_test(cur_test, fail_cnt - test_start);
    $display("checks run %0d, failed %0d; tests passed %0d, failed %0d",
             check_cnt, fail_cnt, test_pass, test_fail);
    if (fail_cnt == 0 && op_q.size() > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, sized by the length of the stimulus table
  initial begin
    wait (loaded);
    repeat (op_q.size() * wd_per_line + 16) @(posedge clk);
    $display("ERROR: the run did not finish within its cycle budget");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* subsys_stim.txt */
# test op addr data expect err, all hex except test and err
# W write, R read, P pins (addr 0 gpio_in, 1 inspect/rtc/wdg), K toggles, I outputs, S stall
1 W 10010008 0000ffff 00000000 0
1 W 1001000c a5a55a5a 00000000 0
1 R 10010008 00000000 0000ffff 0
1 R 1001000c 00000000 a5a55a5a 0
1 I 00000001 00000000 a5a55a5a 0
1 I 00000002 00000000 0000ffff 0
2 S 00000000 00000004 00000000 0
2 R 20000000 00000000 00000000 1
2 S 00000000 00000003 00000000 0
2 W 00000010 12345678 00000000 1
3 W 02000000 00000001 00000000 0
3 I 00000000 00000000 00000001 0
3 K 00000000 00000005 00000000 0
3 R 0200bff8 00000000 00000005 0
3 R 0200bffc 00000000 00000000 0
3 W 02004004 00000000 00000000 0
3 W 02004000 00000005 00000000 0
3 I 00000000 00000000 00000003 0
3 W 02004000 00000006 00000000 0
3 W 02000000 00000000 00000000 0
3 I 00000000 00000000 00000000 0
4 W 0c002000 00000002 00000000 0
4 P 00000001 00000001 00000000 0
4 I 00000000 00000000 00000004 0
4 R 0c002004 00000000 00000001 0
4 I 00000000 00000000 00000000 0
4 W 0c002004 00000001 00000000 0
4 I 00000000 00000000 00000004 0
4 R 0c001000 00000000 00000002 0
4 P 00000001 00000000 00000000 0
4 R 0c002004 00000000 00000001 0
4 W 0c002004 00000001 00000000 0
4 I 00000000 00000000 00000000 0
5 W 10010018 00000010 00000000 0
5 W 0c002000 00000008 00000000 0
5 P 00000000 00000010 00000000 0
5 I 00000000 00000000 00000004 0
5 R 1001001c 00000000 00000010 0
5 R 0c002004 00000000 00000003 0
5 W 1001001c 00000010 00000000 0
5 W 0c002004 00000003 00000000 0
5 I 00000000 00000000 00000000 0
5 R 1001001c 00000000 00000000 0
6 P 00000001 00000004 00000000 0
6 R 0200bff8 00000000 00000005 0
6 I 00000002 00000000 ffffffff 0
6 I 00000003 00000000 00000000 0

/* subsys_main.f */
subsys_pkg.sv
subsys_fabric.sv
subsys_clint.sv
subsys_plic.sv
subsys_gpio.sv
subsys_main.sv
tb_subsys_main.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_subsys_main -f subsys_main.f -o sim_subsys > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_subsys > sim.log 2>&1
cat sim.log

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
